//--- list.f
+incdir+src
src/fma_pkg.sv
src/fma_mul_stage.sv
src/fma_add_stage.sv
src/fma_round_stage.sv
src/fma_unit.sv
test/fma_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module fma_tb -o fma_sim || exit 1
out=$(./obj_dir/fma_sim 2>&1)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src/fma_add_stage.sv
`timescale 1ns/1ps

`include "fma_config.svh"

module fma_add_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    advance,

    input  logic                                    valid_in,
    input  logic [`FMA_TAGW-1:0]                    tag_in,
    input  fma_pkg::fma_op_t                        op,
    input  fma_pkg::prod_t [`FMA_LANES-1:0]         prod,
    input  fma_pkg::prod_t [`FMA_LANES-1:0]         caln,

    output logic                                    valid_out,
    output logic [`FMA_TAGW-1:0]                    tag_out,
    output fma_pkg::fma_op_t                        op_out,
    output fma_pkg::sum_t [`FMA_LANES-1:0]          sum
);

    logic                                   valid_r;
    logic [`FMA_TAGW-1:0]                   tag_r;
    fma_pkg::fma_op_t                       op_r;
    fma_pkg::sum_t [`FMA_LANES-1:0]         sum_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (advance) begin
            valid_r <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_r <= tag_in;
            op_r  <= op;
            for (int i = 0; i < `FMA_LANES; i++) begin
                // widened so the sum is exact.
                if (op[0]) begin
                    sum_r[i] <= fma_pkg::sum_t'($signed(prod[i])) -
                                fma_pkg::sum_t'($signed(caln[i]));
                end else begin
                    sum_r[i] <= fma_pkg::sum_t'($signed(prod[i])) +
                                fma_pkg::sum_t'($signed(caln[i]));
                end
            end
        end
    end

    assign valid_out = valid_r;
    assign tag_out   = tag_r;
    assign op_out    = op_r;
    assign sum       = sum_r;

    // the negate select must not change under a held item.
    op_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (!advance && valid_out) |=> $stable(op_out)
    );

endmodule

//--- src/fma_config.svh
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

// number of parallel lanes per request.
`define FMA_LANES 4

// width of the request tag.
`define FMA_TAGW 6

// fraction bits of the Q16.16 operand format.
`define FMA_FRAC 16

// register stages from request to result.
`define FMA_DEPTH 3

`endif

//--- src/fma_mul_stage.sv
`timescale 1ns/1ps

`include "fma_config.svh"

module fma_mul_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    advance,

    input  logic                                    valid_in,
    input  logic [`FMA_TAGW-1:0]                    tag_in,
    input  fma_pkg::fma_op_t                        op,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          a,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          b,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          c,

    output logic                                    valid_out,
    output logic [`FMA_TAGW-1:0]                    tag_out,
    output fma_pkg::fma_op_t                        op_out,
    output fma_pkg::prod_t [`FMA_LANES-1:0]         prod,
    output fma_pkg::prod_t [`FMA_LANES-1:0]         caln
);

    logic                                   valid_r;
    logic [`FMA_TAGW-1:0]                   tag_r;
    fma_pkg::fma_op_t                       op_r;
    fma_pkg::prod_t [`FMA_LANES-1:0]        prod_r;
    fma_pkg::prod_t [`FMA_LANES-1:0]        caln_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (advance) begin
            valid_r <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_r <= tag_in;
            op_r  <= op;
            for (int i = 0; i < `FMA_LANES; i++) begin
                // Q16.16 times Q16.16 gives Q32.32 exactly.
                prod_r[i] <= fma_pkg::prod_t'($signed(a[i])) *
                             fma_pkg::prod_t'($signed(b[i]));
                // bring c up to the product scale.
                caln_r[i] <= fma_pkg::prod_t'($signed(c[i])) <<< `FMA_FRAC;
            end
        end
    end

    assign valid_out = valid_r;
    assign tag_out   = tag_r;
    assign op_out    = op_r;
    assign prod      = prod_r;
    assign caln      = caln_r;

endmodule

//--- src/fma_pkg.sv
package fma_pkg;

    // signed Q16.16 operand or result.
    typedef logic signed [31:0] fix_t;

    // signed Q32.32 product, also the scale of the aligned addend.
    typedef logic signed [63:0] prod_t;

    // exact sum, two guard bits above the product.
    typedef logic signed [65:0] sum_t;

    // bit 0 subtracts c, bit 1 negates the final sum.
    typedef enum logic [1:0] {
        op_madd  = 2'b00,
        op_msub  = 2'b01,
        op_nmsub = 2'b11,
        op_nmadd = 2'b10
    } fma_op_t;

    // saturation limits of the result.
    localparam fix_t fix_max = 32'sh7fff_ffff;
    localparam fix_t fix_min = 32'sh8000_0000;

endpackage

//--- src/fma_round_stage.sv
`timescale 1ns/1ps

`include "fma_config.svh"

module fma_round_stage (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    advance,

    input  logic                                    valid_in,
    input  logic [`FMA_TAGW-1:0]                    tag_in,
    input  fma_pkg::fma_op_t                        op,
    input  fma_pkg::sum_t [`FMA_LANES-1:0]          sum,

    output logic                                    valid_out,
    output logic [`FMA_TAGW-1:0]                    tag_out,
    output fma_pkg::fix_t [`FMA_LANES-1:0]          result,
    output logic [`FMA_LANES-1:0]                   sat
);

    localparam fma_pkg::sum_t half_lsb = fma_pkg::sum_t'(1) <<< (`FMA_FRAC - 1);

    logic                                   valid_r;
    logic [`FMA_TAGW-1:0]                   tag_r;
    fma_pkg::fix_t [`FMA_LANES-1:0]         result_r;
    logic [`FMA_LANES-1:0]                  sat_r;

    fma_pkg::fix_t [`FMA_LANES-1:0]         result_next;
    logic [`FMA_LANES-1:0]                  sat_next;

    always_comb begin : round_lanes
        fma_pkg::sum_t signed_sum;
        fma_pkg::sum_t rounded;
        fma_pkg::sum_t shifted;
        for (int i = 0; i < `FMA_LANES; i++) begin
            signed_sum = op[1] ? -sum[i] : sum[i];
            // nearest, ties go toward plus infinity.
            rounded = signed_sum + half_lsb;
            shifted = rounded >>> `FMA_FRAC;
            if (shifted > fma_pkg::sum_t'(fma_pkg::fix_max)) begin
                result_next[i] = fma_pkg::fix_max;
                sat_next[i]    = 1'b1;
            end else if (shifted < fma_pkg::sum_t'(fma_pkg::fix_min)) begin
                result_next[i] = fma_pkg::fix_min;
                sat_next[i]    = 1'b1;
            end else begin
                result_next[i] = fma_pkg::fix_t'(shifted);
                sat_next[i]    = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (advance) begin
            valid_r <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_r    <= tag_in;
            result_r <= result_next;
            sat_r    <= sat_next;
        end
    end

    assign valid_out = valid_r;
    assign tag_out   = tag_r;
    assign result    = result_r;
    assign sat       = sat_r;

    for (genvar i = 0; i < `FMA_LANES; i++) begin : g_sat_check
        // a flagged lane sits on one of the two rails.
        sat_rail_a: assert property (
            @(posedge clk) disable iff (reset)
            (valid_out && sat[i]) |->
                (result[i] == fma_pkg::fix_max || result[i] == fma_pkg::fix_min)
        );
    end

endmodule

//--- src/fma_unit.sv
`timescale 1ns/1ps

`include "fma_config.svh"

module fma_unit (
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    valid_in,
    output logic                                    ready_in,
    input  fma_pkg::fma_op_t                        op,
    input  logic [`FMA_TAGW-1:0]                    tag_in,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          a,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          b,
    input  fma_pkg::fix_t [`FMA_LANES-1:0]          c,

    output logic                                    valid_out,
    input  logic                                    ready_out,
    output fma_pkg::fix_t [`FMA_LANES-1:0]          result,
    output logic [`FMA_LANES-1:0]                   sat,
    output logic [`FMA_TAGW-1:0]                    tag_out
);

    logic                                   stall;
    logic                                   advance;

    logic                                   mul_valid;
    logic [`FMA_TAGW-1:0]                   mul_tag;
    fma_pkg::fma_op_t                       mul_op;
    fma_pkg::prod_t [`FMA_LANES-1:0]        mul_prod;
    fma_pkg::prod_t [`FMA_LANES-1:0]        mul_caln;

    logic                                   add_valid;
    logic [`FMA_TAGW-1:0]                   add_tag;
    fma_pkg::fma_op_t                       add_op;
    fma_pkg::sum_t [`FMA_LANES-1:0]         add_sum;

    // whole pipe freezes, bubbles included.
    assign stall    = valid_out && !ready_out;
    assign advance  = !stall;
    assign ready_in = advance;

    fma_mul_stage mul_stage (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .valid_in  (valid_in),
        .tag_in    (tag_in),
        .op        (op),
        .a         (a),
        .b         (b),
        .c         (c),
        .valid_out (mul_valid),
        .tag_out   (mul_tag),
        .op_out    (mul_op),
        .prod      (mul_prod),
        .caln      (mul_caln)
    );

    fma_add_stage add_stage (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .valid_in  (mul_valid),
        .tag_in    (mul_tag),
        .op        (mul_op),
        .prod      (mul_prod),
        .caln      (mul_caln),
        .valid_out (add_valid),
        .tag_out   (add_tag),
        .op_out    (add_op),
        .sum       (add_sum)
    );

    fma_round_stage round_stage (
        .clk       (clk),
        .reset     (reset),
        .advance   (advance),
        .valid_in  (add_valid),
        .tag_in    (add_tag),
        .op        (add_op),
        .sum       (add_sum),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .result    (result),
        .sat       (sat)
    );

    // held output must not change under back-pressure.
    out_hold_a: assert property (
        @(posedge clk) disable iff (reset)
        (valid_out && !ready_out) |=> ($stable(result) && $stable(sat) && $stable(tag_out))
    );

    // an accepted item reaches the output after the pipe depth when never stalled.
    latency_a: assert property (
        @(posedge clk) disable iff (reset)
        (valid_in && ready_in) ##1 ready_in [* (`FMA_DEPTH - 1)] |-> ##1 valid_out
    );

endmodule

//--- test/fma_tb.sv
`timescale 1ns/1ps

`include "fma_config.svh"

module fma_tb;

    localparam int n_txn        = 2000;
    localparam int burst_len    = 16;
    localparam int reset_cycles = 16;
    localparam int clk_period   = 4;
    localparam int res_w        = `FMA_LANES * 32;
    localparam int timeout_ns   = (n_txn * 20 + reset_cycles + burst_len * `FMA_DEPTH) * clk_period;

    logic                                   clk;
    logic                                   reset;
    logic                                   valid_in;
    logic                                   ready_in;
    fma_pkg::fma_op_t                       op;
    logic [`FMA_TAGW-1:0]                   tag_in;
    fma_pkg::fix_t [`FMA_LANES-1:0]         a;
    fma_pkg::fix_t [`FMA_LANES-1:0]         b;
    fma_pkg::fix_t [`FMA_LANES-1:0]         c;
    logic                                   valid_out;
    logic                                   ready_out;
    fma_pkg::fix_t [`FMA_LANES-1:0]         result;
    logic [`FMA_LANES-1:0]                  sat;
    logic [`FMA_TAGW-1:0]                   tag_out;

    logic [31:0]                            rng_state;
    int                                     cyc;
    int                                     n_in;
    int                                     n_out;
    int                                     first_in;
    int                                     last_out;
    logic                                   burst_mode;
    logic                                   hold_pending;
    logic [res_w-1:0]                       held_res;
    logic [`FMA_LANES-1:0]                  held_sat;
    logic [`FMA_TAGW-1:0]                   held_tag;

    // expected items in issue order.
    logic [`FMA_TAGW-1:0]                   exp_tag[$];
    logic [res_w-1:0]                       exp_res[$];
    logic [`FMA_LANES-1:0]                  exp_sat[$];

    fma_unit DUT (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .op        (op),
        .tag_in    (tag_in),
        .a         (a),
        .b         (b),
        .c         (c),
        .valid_out (valid_out),
        .ready_out (ready_out),
        .result    (result),
        .sat       (sat),
        .tag_out   (tag_out)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [res_w-1:0] got,
                               input logic [res_w-1:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // exact sum at 66 bits, then round half up and clamp.
    task automatic model_lane(input logic signed [31:0] av, input logic signed [31:0] bv,
                              input logic signed [31:0] cv, input fma_pkg::fma_op_t opv,
                              output logic [31:0] res, output logic sat_bit);
        logic signed [65:0] prod, addend, total, rounded;
        prod   = 66'(av) * 66'(bv);
        addend = 66'(cv) <<< 16;
        case (opv)
            fma_pkg::op_madd:  total = prod + addend;
            fma_pkg::op_msub:  total = prod - addend;
            fma_pkg::op_nmsub: total = addend - prod;
            default:           total = -prod - addend;
        endcase
        rounded = (total + 66'sd32768) >>> 16;
        sat_bit = 1'b1;
        if (rounded > 66'sd2147483647) begin
            res = 32'h7fff_ffff;
        end else if (rounded < -66'sd2147483648) begin
            res = 32'h8000_0000;
        end else begin
            res     = rounded[31:0];
            sat_bit = 1'b0;
        end
    endtask

    task automatic draw_lane(output logic [31:0] av, output logic [31:0] bv,
                             output logic [31:0] cv);
        logic [31:0] mix;
        logic [31:0] r;
        logic [31:0] s;
        mix = next_rand() % 3;
        r   = next_rand();
        s   = next_rand();
        case (mix)
            // small values on 8 fraction bits keep products exact.
            0: begin
                av = {{12{r[19]}}, r[19:8], 8'h00};
                bv = {{12{s[19]}}, s[19:8], 8'h00};
                cv = {{12{s[31]}}, s[31:20], 8'h00};
            end
            1: begin
                av = r;
                bv = s;
                cv = next_rand();
            end
            // product fraction is exactly one half.
            default: begin
                av = r[0] ? 32'hffff_ffff : 32'h0000_0001;
                bv = {r[16:1], 1'b1, 15'h0000};
                cv = {{12{s[19]}}, s[19:8], 8'h00};
            end
        endcase
    endtask

    task automatic drive_operands();
        fma_pkg::fix_t [`FMA_LANES-1:0] a_row;
        fma_pkg::fix_t [`FMA_LANES-1:0] b_row;
        fma_pkg::fix_t [`FMA_LANES-1:0] c_row;
        logic [31:0] av, bv, cv;
        for (int i = 0; i < `FMA_LANES; i++) begin
            draw_lane(av, bv, cv);
            a_row[i] = av;
            b_row[i] = bv;
            c_row[i] = cv;
        end
        a      <= a_row;
        b      <= b_row;
        c      <= c_row;
        op     <= fma_pkg::fma_op_t'(2'(next_rand()));
        tag_in <= `FMA_TAGW'(next_rand());
    endtask

    task automatic observe();
        logic [res_w-1:0] res_row;
        logic [`FMA_LANES-1:0] sat_row;
        logic [31:0] lane_res;
        logic lane_sat;
        cyc = cyc + 1;
        if (reset) begin
            if (cyc > 1) begin
                check_value("valid_out in reset", res_w'(valid_out), res_w'(0));
                check_value("ready_in in reset", res_w'(ready_in), res_w'(1));
            end
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                check_value("held result", result, held_res);
                check_value("held sat", res_w'(sat), res_w'(held_sat));
                check_value("held tag_out", res_w'(tag_out), res_w'(held_tag));
            end
            if (valid_in && ready_in) begin
                for (int i = 0; i < `FMA_LANES; i++) begin
                    model_lane(a[i], b[i], c[i], op, lane_res, lane_sat);
                    res_row[i*32 +: 32] = lane_res;
                    sat_row[i]          = lane_sat;
                end
                exp_tag.push_back(tag_in);
                exp_res.push_back(res_row);
                exp_sat.push_back(sat_row);
                if (burst_mode && first_in < 0) begin
                    first_in = cyc;
                end
                n_in = n_in + 1;
            end
            if (valid_out && ready_out) begin
                if (exp_tag.size() == 0) begin
                    abort_run("an output arrived while no accepted request was pending");
                end
                check_value("tag_out", res_w'(tag_out), res_w'(exp_tag.pop_front()));
                check_value("result", result, exp_res.pop_front());
                check_value("sat", res_w'(sat), res_w'(exp_sat.pop_front()));
                if (burst_mode) begin
                    if (last_out < 0) begin
                        check_value("first latency", res_w'(cyc - first_in), res_w'(`FMA_DEPTH));
                    end else begin
                        check_value("burst spacing", res_w'(cyc - last_out), res_w'(1));
                    end
                    last_out = cyc;
                end
                n_out = n_out + 1;
            end
            hold_pending = valid_out && !ready_out;
            held_res     = result;
            held_sat     = sat;
            held_tag     = tag_out;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        observe();
    endtask

    initial begin
        #(timeout_ns);
        abort_run("timed out: outputs stopped arriving before all requests completed");
    end

    initial begin
        rng_state    = 32'hd652508e;
        reset        <= 1'b1;
        valid_in     <= 1'b0;
        ready_out    <= 1'b0;
        op           <= fma_pkg::op_madd;
        tag_in       <= '0;
        a            <= '0;
        b            <= '0;
        c            <= '0;
        cyc          = 0;
        n_in         = 0;
        n_out        = 0;
        first_in     = -1;
        last_out     = -1;
        burst_mode   = 1'b0;
        hold_pending = 1'b0;
        repeat (reset_cycles) tick();
        reset <= 1'b0;
        tick();
        check_value("valid_out after reset", res_w'(valid_out), res_w'(0));
        check_value("ready_in after reset", res_w'(ready_in), res_w'(1));

        // back to back with the pipe empty.
        burst_mode = 1'b1;
        ready_out <= 1'b1;
        valid_in  <= 1'b1;
        for (int k = 0; k < burst_len; k++) begin
            drive_operands();
            tick();
        end
        valid_in <= 1'b0;
        while (n_out < n_in) tick();
        check_value("burst outputs", res_w'(n_out), res_w'(burst_len));
        burst_mode = 1'b0;

        while (n_in < n_txn) begin
            valid_in  <= (next_rand() % 10) < 7;
            ready_out <= (next_rand() % 10) < 6;
            drive_operands();
            tick();
        end
        valid_in  <= 1'b0;
        ready_out <= 1'b1;
        while (n_out < n_in) tick();
        // stray or repeated outputs would show up here.
        repeat (2 * `FMA_DEPTH) tick();
        if (n_out == n_in && exp_tag.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("the number of outputs does not match the number of accepted requests");
        end
    end

endmodule
